// File: verilog.f
+incdir+include
hdl/cnn_ctrl_pkg.sv
hdl/cnn_data_pkg.sv
hdl/cnn_axil_regs.sv
hdl/cnn_layer_ctrl.sv
hdl/cnn_conv_core.sv
hdl/cnn_out_serializer.sv
hdl/cnn_img_mem.sv
hdl/cnn_accel_top.sv
bench/tb_cnn_accel.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_cnn_accel -o sim_tb

run: build
	@out=$$(./obj_dir/sim_tb); echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module cnn_accel_top

clean:
	rm -rf obj_dir

// File: bench/tb_cnn_accel.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module tb_cnn_accel;

  localparam int CLK_NS = 20;

  logic        clk;
  logic        xrst;
  logic [11:0] s_awaddr;
  logic        s_awvalid;
  logic        s_awready;
  logic [31:0] s_wdata;
  logic [3:0]  s_wstrb;
  logic        s_wvalid;
  logic        s_wready;
  logic [1:0]  s_bresp;
  logic        s_bvalid;
  logic        s_bready;
  logic [11:0] s_araddr;
  logic        s_arvalid;
  logic        s_arready;
  logic [31:0] s_rdata;
  logic [1:0]  s_rresp;
  logic        s_rvalid;
  logic        s_rready;

  int          img [64];
  int          wts [4][10];
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;

  cnn_accel_top dut0 (
    .clk, .xrst,
    .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready
  );

  always #(CLK_NS / 2) clk = ~clk;

//============================================================
// AXI4-Lite rules
//============================================================

  task automatic protocol_error(input string msg);
    errors++;
    $display("AXI rule broken at %0t ns: %s", $time, msg);
  endtask

  assert property (@(posedge clk) disable iff (!xrst) s_bvalid && !s_bready |=> s_bvalid)
    else protocol_error("bvalid dropped before bready");
  assert property (@(posedge clk) disable iff (!xrst) s_rvalid && !s_rready |=> s_rvalid)
    else protocol_error("rvalid dropped before rready");
  assert property (@(posedge clk) disable iff (!xrst) s_awready |-> s_awvalid && s_wvalid)
    else protocol_error("awready high without a valid write");
  assert property (@(posedge clk) disable iff (!xrst) s_wready |-> s_wvalid)
    else protocol_error("wready high without wvalid");
  assert property (@(posedge clk) disable iff (!xrst) s_awready == s_wready)
    else protocol_error("awready and wready did not pulse together");
  assert property (@(posedge clk) disable iff (!xrst) s_arready |-> s_arvalid)
    else protocol_error("arready high without arvalid");
  assert property (@(posedge clk) disable iff (!xrst) s_bvalid |-> s_bresp == 2'b00)
    else protocol_error("write response is not OKAY");
  assert property (@(posedge clk) disable iff (!xrst) s_rvalid |-> s_rresp == 2'b00)
    else protocol_error("read response is not OKAY");

//============================================================
// stimulus helpers
//============================================================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return int'(v);
  endfunction

  function automatic logic [11:0] img_addr(input int a);
    return 12'(`CNN_IMG_BASE + a * 4);
  endfunction

  function automatic int guard_word(input int a);
    return ((a * 263) ^ 'h3c5a) & 'h7fff;
  endfunction

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
    logic seen;
    s_awaddr  = addr;
    s_wdata   = data;
    s_wstrb   = 4'hf;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    do begin
      @(negedge clk);
      seen = s_awready;
      @(posedge clk);
      #1;
    end while (!seen);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    // bready comes one cycle late on purpose
    do begin
      @(negedge clk);
      seen = s_bvalid;
      @(posedge clk);
      #1;
    end while (!seen);
    s_bready = 1'b1;
    @(posedge clk);
    #1;
    s_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
    logic seen;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    do begin
      @(negedge clk);
      seen = s_arready;
      @(posedge clk);
      #1;
    end while (!seen);
    s_arvalid = 1'b0;
    do begin
      @(negedge clk);
      seen = s_rvalid;
      data = s_rdata;
      @(posedge clk);
      #1;
    end while (!seen);
    s_rready = 1'b1;
    @(posedge clk);
    #1;
    s_rready = 1'b0;
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERROR %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

//============================================================
// reference model and layer runs
//============================================================

  // 3x3 MAC plus bias, >> 8, relu, saturate
  function automatic int expected_out(input int s, input int c, input int oy, input int ox);
    longint sum;
    longint sh;
    sum = wts[c][9];
    for (int ky = 0; ky < 3; ky++)
      for (int kx = 0; kx < 3; kx++)
        sum = sum + longint'(img[(oy + ky) * s + ox + kx]) * wts[c][ky * 3 + kx];
    sh = sum >>> `CNN_FRAC;
    if (sh < 0)
      return 0;
    if (sh > 32767)
      return 32767;
    return int'(sh);
  endfunction

  // non-negative activations, signed weights and bias
  task automatic random_layer(input int s, input int nout);
    for (int i = 0; i < s * s; i++)
      img[i] = rand_bits(9);
    for (int c = 0; c < nout; c++) begin
      for (int k = 0; k < 9; k++)
        wts[c][k] = rand_bits(8) - 128;
      wts[c][9] = rand_bits(10) - 512;
    end
  endtask

  task automatic run_layer(input int s, input int nout, input int in_off, input int out_off);
    logic [31:0] rd;
    int          osz;
    int          a;
    osz = s - 2;
    for (int i = 0; i < s * s; i++)
      axi_write(img_addr(in_off + i), 32'(img[i]));
    // core c % 2, pass c / 2
    for (int c = 0; c < nout; c++)
      for (int k = 0; k < 10; k++)
        axi_write(12'(`CNN_NET_BASE + (c % 2) * 256 + ((c / 2) * 10 + k) * 4), 32'(wts[c][k]));
    axi_write(`CNN_REG_IMG_SIZE, 32'(s));
    axi_write(`CNN_REG_TOTAL_OUT, 32'(nout));
    axi_write(`CNN_REG_IN_OFFSET, 32'(in_off));
    axi_write(`CNN_REG_OUT_OFFSET, 32'(out_off));
    axi_write(`CNN_REG_CTRL, 32'd1);
    axi_read(`CNN_REG_STATUS, rd);
    check_value("done after start", rd, 32'd0);
    do begin
      axi_read(`CNN_REG_STATUS, rd);
    end while (rd[0] == 1'b0);
    for (int c = 0; c < nout; c++)
      for (int oy = 0; oy < osz; oy++)
        for (int ox = 0; ox < osz; ox++) begin
          a = out_off + c * osz * osz + oy * osz + ox;
          axi_read(img_addr(a), rd);
          check_value($sformatf("channel %0d y %0d x %0d", c, oy, ox), rd,
                      32'(expected_out(s, c, oy, ox)));
        end
  endtask

  function automatic int layer_cycles(input int s, input int nout);
    int osz;
    int writes;
    int reads;
    osz    = s - 2;
    writes = s * s + nout * 10 + 5;
    reads  = nout * osz * osz + 4;
    return (nout + 1) / 2 * (`CNN_NET_WORDS + osz * osz * 9 + 8) + writes * 4 + reads * 5;
  endfunction

  // watchdog
  initial begin
    longint limit_ns;
    limit_ns = 2 * CLK_NS * longint'(16 + 500 + 4 * layer_cycles(6, 2) + layer_cycles(8, 4));
    #(limit_ns);
    $display("timeout: the tests did not finish within %0d ns", limit_ns);
    $display("STATUS: FAIL");
    $finish;
  end

//============================================================
// tests
//============================================================

  initial begin
    logic [31:0] rd;
    int          e0;
    clk       = 1'b0;
    xrst      = 1'b0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    lfsr      = 32'h3d3a401c;
    errors    = 0;
    checks    = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    #1;
    xrst = 1'b1;
    @(posedge clk);
    #1;

    e0 = errors;
    axi_read(`CNN_REG_STATUS, rd);
    check_value("status after reset", rd, 32'd1);
    axi_write(`CNN_REG_IMG_SIZE, 32'd6);
    axi_write(`CNN_REG_TOTAL_OUT, 32'd4);
    axi_write(`CNN_REG_IN_OFFSET, 32'h1a5);
    axi_write(`CNN_REG_OUT_OFFSET, 32'h0c3);
    axi_read(`CNN_REG_IMG_SIZE, rd);
    check_value("img_size", rd, 32'd6);
    axi_read(`CNN_REG_TOTAL_OUT, rd);
    check_value("total_out", rd, 32'd4);
    axi_read(`CNN_REG_IN_OFFSET, rd);
    check_value("in_offset", rd, 32'h1a5);
    axi_read(`CNN_REG_OUT_OFFSET, rd);
    check_value("out_offset", rd, 32'h0c3);
    axi_write(img_addr(100), 32'h0000_8a51);
    axi_read(img_addr(100), rd);
    check_value("image word sign extension", rd, 32'hffff_8a51);
    // core 1, word 5
    axi_write(12'(`CNN_NET_BASE + 256 + 5 * 4), 32'h0000_f0f3);
    axi_read(12'(`CNN_NET_BASE + 256 + 5 * 4), rd);
    check_value("weight word sign extension", rd, 32'hffff_f0f3);
    end_test("registers after reset", e0);

    e0 = errors;
    random_layer(6, 2);
    run_layer(6, 2, 0, 128);
    end_test("6x6 image, 2 channels", e0);

    e0 = errors;
    random_layer(8, 4);
    run_layer(8, 4, 0, 128);
    end_test("8x8 image, 4 channels", e0);

    // channel 0 saturates, channel 1 stays below zero
    e0 = errors;
    for (int i = 0; i < 36; i++)
      img[i] = 256 + rand_bits(8);
    for (int k = 0; k < 9; k++) begin
      wts[0][k] = 32767;
      wts[1][k] = rand_bits(2);
    end
    wts[0][9] = 0;
    wts[1][9] = -16384;
    run_layer(6, 2, 0, 128);
    axi_read(img_addr(128), rd);
    check_value("saturated output", rd, 32'h7fff);
    axi_read(img_addr(128 + 16), rd);
    check_value("relu output", rd, 32'd0);
    end_test("saturation and relu", e0);

    e0 = errors;
    random_layer(6, 2);
    for (int k = 0; k < 9; k++) begin
      wts[0][k] = 0;
      wts[1][k] = 0;
    end
    wts[0][9] = rand_bits(14);
    wts[1][9] = -1 - rand_bits(14);
    run_layer(6, 2, 0, 128);
    axi_read(img_addr(128), rd);
    check_value("positive bias only", rd, 32'(wts[0][9] / 256));
    axi_read(img_addr(128 + 16), rd);
    check_value("negative bias only", rd, 32'd0);
    end_test("bias-only kernels", e0);

    // guard words on both sides of the output region
    e0 = errors;
    for (int a = 36; a < 40; a++)
      axi_write(img_addr(a), 32'(guard_word(a)));
    for (int a = 72; a < 76; a++)
      axi_write(img_addr(a), 32'(guard_word(a)));
    random_layer(6, 2);
    run_layer(6, 2, 300, 40);
    for (int a = 36; a < 76; a++)
      if (a < 40 || a >= 72) begin
        axi_read(img_addr(a), rd);
        check_value($sformatf("guard word %0d", a), rd, 32'(guard_word(a)));
      end
    for (int i = 0; i < 36; i++) begin
      axi_read(img_addr(300 + i), rd);
      check_value($sformatf("input word %0d", i), rd, 32'(img[i]));
    end
    end_test("memory offsets", e0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: hdl/cnn_accel_top.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module cnn_accel_top (
  input  logic        clk,
  input  logic        xrst,
  input  logic [11:0] s_awaddr,
  input  logic        s_awvalid,
  output logic        s_awready,
  input  logic [31:0] s_wdata,
  input  logic [3:0]  s_wstrb,
  input  logic        s_wvalid,
  output logic        s_wready,
  output logic [1:0]  s_bresp,
  output logic        s_bvalid,
  input  logic        s_bready,
  input  logic [11:0] s_araddr,
  input  logic        s_arvalid,
  output logic        s_arready,
  output logic [31:0] s_rdata,
  output logic [1:0]  s_rresp,
  output logic        s_rvalid,
  input  logic        s_rready
);
  import cnn_ctrl_pkg::*;
  import cnn_data_pkg::*;

  logic                   start;
  logic                   done;
  logic                   idle;
  layer_cfg_t             cfg;
  ctrl_bus_t              ctrl;
  mem_wr_t                host_img_wr;
  mem_wr_t                net_wr;
  mem_wr_t                out_wr;
  logic                   net_sel;
  logic [`CNN_IMG_AW-1:0] host_img_raddr;
  logic [`CNN_IMG_AW-1:0] img_raddr;
  logic [`CNN_NET_AW-1:0] net_raddr;
  pixel_t                 host_img_rdata;
  pixel_t                 pixel;
  weight_t                net_host_rdata [`CNN_NCORE];
  pixel_t                 result [`CNN_NCORE];
  logic [`CNN_NCORE-1:0]  result_valid;

  cnn_axil_regs regs0 (
    .clk, .xrst,
    .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .start, .cfg, .done,
    .host_img_wr, .host_img_raddr, .host_img_rdata,
    .net_wr, .net_sel, .net_host_rdata
  );

  cnn_layer_ctrl ctrl0 (
    .clk, .xrst, .start, .cfg, .idle, .done, .img_raddr, .net_raddr, .ctrl
  );

  cnn_conv_core #(.CORE_ID(0)) core0 (
    .clk, .xrst, .net_wr, .net_sel, .net_raddr,
    .net_host_rdata(net_host_rdata[0]),
    .ctrl, .pixel_in(pixel),
    .result(result[0]), .result_valid(result_valid[0])
  );

  cnn_conv_core #(.CORE_ID(1)) core1 (
    .clk, .xrst, .net_wr, .net_sel, .net_raddr,
    .net_host_rdata(net_host_rdata[1]),
    .ctrl, .pixel_in(pixel),
    .result(result[1]), .result_valid(result_valid[1])
  );

  cnn_out_serializer ser0 (
    .clk, .xrst, .cfg, .ctrl,
    .result0(result[0]), .result1(result[1]), .result_valid,
    .out_wr, .idle
  );

  cnn_img_mem mem0 (
    .clk,
    .host_wr(host_img_wr), .out_wr,
    .raddr_a(img_raddr), .rdata_a(pixel),
    .raddr_b(host_img_raddr), .rdata_b(host_img_rdata)
  );

endmodule

// File: hdl/cnn_img_mem.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module cnn_img_mem (
  input  logic                   clk,
  input  cnn_data_pkg::mem_wr_t  host_wr,
  input  cnn_data_pkg::mem_wr_t  out_wr,
  input  logic [`CNN_IMG_AW-1:0] raddr_a,
  output cnn_data_pkg::pixel_t   rdata_a,
  input  logic [`CNN_IMG_AW-1:0] raddr_b,
  output cnn_data_pkg::pixel_t   rdata_b
);
  import cnn_data_pkg::*;

  pixel_t  mem [2 ** `CNN_IMG_AW];
  mem_wr_t wr;

  // results win over host writes
  assign wr = out_wr.we ? out_wr : host_wr;

  always_ff @(posedge clk) begin
    if (wr.we)
      mem[wr.addr] <= wr.data;
    rdata_a <= mem[raddr_a];
    rdata_b <= mem[raddr_b];
  end

endmodule

// File: hdl/cnn_out_serializer.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module cnn_out_serializer (
  input  logic                        clk,
  input  logic                        xrst,
  input  cnn_ctrl_pkg::layer_cfg_t    cfg,
  input  cnn_ctrl_pkg::ctrl_bus_t     ctrl,
  input  cnn_data_pkg::pixel_t        result0,
  input  cnn_data_pkg::pixel_t        result1,
  input  logic [`CNN_NCORE-1:0]       result_valid,
  output cnn_data_pkg::mem_wr_t       out_wr,
  output logic                        idle
);
  import cnn_data_pkg::*;

  localparam int IAW = `CNN_IMG_AW;

  logic [IAW-1:0] osz;
  logic [IAW-1:0] base_addr;
  pixel_t         hold1;
  logic           win_stop;
  logic           wait_res;
  logic           second;

  assign osz      = IAW'(cfg.img_size) - IAW'(`CNN_KSIZE - 1);
  assign win_stop = ctrl.valid && ctrl.stop && !ctrl.load;
  assign idle     = !(wait_res || second || out_wr.we);

  always_ff @(posedge clk) begin
    if (win_stop)
      base_addr <= ctrl.out_addr;
    if (&result_valid)
      hold1 <= result1;
  end

  // core 0 first, core 1 one channel plane further
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wait_res <= 1'b0;
      second   <= 1'b0;
      out_wr   <= '0;
    end else begin
      wait_res    <= win_stop;
      second      <= &result_valid;
      out_wr.we   <= &result_valid || second;
      out_wr.addr <= second ? base_addr + osz * osz : base_addr;
      out_wr.data <= second ? hold1 : result0;
    end
  end

endmodule

// File: hdl/cnn_conv_core.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module cnn_conv_core #(
  parameter int CORE_ID = 0
) (
  input  logic                    clk,
  input  logic                    xrst,
  input  cnn_data_pkg::mem_wr_t   net_wr,
  input  logic                    net_sel,
  input  logic [`CNN_NET_AW-1:0]  net_raddr,
  output cnn_data_pkg::weight_t   net_host_rdata,
  input  cnn_ctrl_pkg::ctrl_bus_t ctrl,
  input  cnn_data_pkg::pixel_t    pixel_in,
  output cnn_data_pkg::pixel_t    result,
  output logic                    result_valid
);
  import cnn_data_pkg::*;

  localparam int   NAW     = `CNN_NET_AW;
  localparam int   KWORDS  = `CNN_KSIZE * `CNN_KSIZE;
  localparam acc_t PIX_MAX = 2 ** (`CNN_DWIDTH - 1) - 1;

  weight_t net_mem [2 ** NAW];
  weight_t net_rdata;
  weight_t kernel [KWORDS];
  weight_t bias;
  acc_t    acc;
  acc_t    acc_sum;
  acc_t    shifted;
  logic    win_stop;

  always_ff @(posedge clk) begin
    if (net_wr.we && net_sel == 1'(CORE_ID))
      net_mem[net_wr.addr[NAW-1:0]] <= net_wr.data;
    net_rdata      <= net_mem[net_raddr];
    net_host_rdata <= net_mem[net_wr.addr[NAW-1:0]];
  end

  // start of a window restarts the sum
  assign acc_sum  = (ctrl.start ? acc_t'(0) : acc) + pixel_in * kernel[ctrl.kidx];
  assign shifted  = (acc_sum + bias) >>> `CNN_FRAC;
  assign win_stop = ctrl.valid && !ctrl.load && ctrl.stop;

  always_ff @(posedge clk) begin
    if (ctrl.valid && ctrl.load) begin
      if (ctrl.kidx < KWORDS)
        kernel[ctrl.kidx] <= net_rdata;
      else
        bias <= net_rdata;
    end
    if (ctrl.valid && !ctrl.load)
      acc <= acc_sum;
    // relu, then saturate
    if (win_stop) begin
      if (shifted < 0)
        result <= '0;
      else if (shifted > PIX_MAX)
        result <= pixel_t'(PIX_MAX);
      else
        result <= pixel_t'(shifted);
    end
  end

  always_ff @(posedge clk)
    if (!xrst)
      result_valid <= 1'b0;
    else
      result_valid <= win_stop;

endmodule

// File: hdl/cnn_layer_ctrl.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module cnn_layer_ctrl (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     start,
  input  cnn_ctrl_pkg::layer_cfg_t cfg,
  input  logic                     idle,
  output logic                     done,
  output logic [`CNN_IMG_AW-1:0]   img_raddr,
  output logic [`CNN_NET_AW-1:0]   net_raddr,
  output cnn_ctrl_pkg::ctrl_bus_t  ctrl
);
  import cnn_ctrl_pkg::*;

  localparam int IAW = `CNN_IMG_AW;
  localparam int NAW = `CNN_NET_AW;
  localparam int LW  = `CNN_LWIDTH;
  localparam int K   = `CNN_KSIZE;

  phase_t         phase;
  layer_cfg_t     cfg_r;
  ctrl_bus_t      bus_next;
  logic           done_r;
  logic [LW-1:0]  pass;
  logic [LW-1:0]  kx;
  logic [LW-1:0]  ky;
  logic [LW-1:0]  ox;
  logic [LW-1:0]  oy;
  logic [1:0]     out_wait;
  logic [3:0]     kidx;
  logic [IAW-1:0] osz;
  logic [IAW-1:0] ch_base;
  logic           last_word;
  logic           last_win;
  logic           last_pass;

  assign osz       = IAW'(cfg_r.img_size) - IAW'(K - 1);
  assign kidx      = 4'(ky * K + kx);
  assign ch_base   = IAW'(`CNN_NCORE * pass) * osz * osz;
  assign last_word = phase == PH_NETWORK ? kidx == `CNN_NET_WORDS - 1 : kidx == K * K - 1;
  assign last_win  = ox == osz - 1 && oy == osz - 1;
  assign last_pass = (pass + 1) * `CNN_NCORE >= cfg_r.total_out;
  assign done      = done_r && !start;

  // addresses are issued now, the bus follows one cycle later
  assign net_raddr = NAW'(pass * `CNN_NET_WORDS + kidx);
  assign img_raddr = cfg_r.in_offset + (oy + ky) * cfg_r.img_size + ox + kx;

  always_ff @(posedge clk)
    if (phase == PH_WAIT && start)
      cfg_r <= cfg;

//============================================================
// phase machine
//============================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      phase    <= PH_WAIT;
      done_r   <= 1'b1;
      pass     <= '0;
      kx       <= '0;
      ky       <= '0;
      ox       <= '0;
      oy       <= '0;
      out_wait <= '0;
    end else begin
      case (phase)
        PH_WAIT:
          if (start) begin
            phase  <= PH_NETWORK;
            done_r <= 1'b0;
            pass   <= '0;
          end
        PH_NETWORK:
          // weights then bias, ky reaches 3 on the bias word
          if (last_word) begin
            ky    <= '0;
            phase <= PH_INPUT;
          end else if (kx == K - 1) begin
            kx <= '0;
            ky <= ky + 1'b1;
          end else begin
            kx <= kx + 1'b1;
          end
        PH_INPUT: begin
          if (kx == K - 1) begin
            kx <= '0;
            ky <= (ky == K - 1) ? '0 : ky + 1'b1;
          end else begin
            kx <= kx + 1'b1;
          end
          if (last_word) begin
            ox <= (ox == osz - 1) ? '0 : ox + 1'b1;
            if (ox == osz - 1)
              oy <= oy + 1'b1;
            if (last_win) begin
              oy       <= '0;
              out_wait <= '0;
              phase    <= PH_OUTPUT;
            end
          end
        end
        PH_OUTPUT:
          // serializer is still busy right after the last stop
          if (out_wait != 2'd3) begin
            out_wait <= out_wait + 1'b1;
          end else if (idle) begin
            if (last_pass) begin
              phase  <= PH_WAIT;
              done_r <= 1'b1;
            end else begin
              pass  <= pass + 1'b1;
              phase <= PH_NETWORK;
            end
          end
      endcase
    end
  end

//============================================================
// control bus
//============================================================

  always_comb begin
    bus_next          = '0;
    bus_next.kidx     = kidx;
    bus_next.out_addr = cfg_r.out_offset + ch_base + oy * osz + ox;
    bus_next.load     = phase == PH_NETWORK;
    bus_next.valid    = phase == PH_NETWORK || phase == PH_INPUT;
    bus_next.start    = bus_next.valid && kidx == 0;
    bus_next.stop     = bus_next.valid && last_word;
  end

  always_ff @(posedge clk)
    if (!xrst)
      ctrl <= '0;
    else
      ctrl <= bus_next;

endmodule

// File: hdl/cnn_axil_regs.sv
`timescale 1ns/1ps
`include "cnn_params.svh"

module cnn_axil_regs (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic [11:0]              s_awaddr,
  input  logic                     s_awvalid,
  output logic                     s_awready,
  input  logic [31:0]              s_wdata,
  input  logic [3:0]               s_wstrb,
  input  logic                     s_wvalid,
  output logic                     s_wready,
  output logic [1:0]               s_bresp,
  output logic                     s_bvalid,
  input  logic                     s_bready,
  input  logic [11:0]              s_araddr,
  input  logic                     s_arvalid,
  output logic                     s_arready,
  output logic [31:0]              s_rdata,
  output logic [1:0]               s_rresp,
  output logic                     s_rvalid,
  input  logic                     s_rready,
  output logic                     start,
  output cnn_ctrl_pkg::layer_cfg_t cfg,
  input  logic                     done,
  output cnn_data_pkg::mem_wr_t    host_img_wr,
  output logic [`CNN_IMG_AW-1:0]   host_img_raddr,
  input  cnn_data_pkg::pixel_t     host_img_rdata,
  output cnn_data_pkg::mem_wr_t    net_wr,
  output logic                     net_sel,
  input  cnn_data_pkg::weight_t    net_host_rdata [`CNN_NCORE]
);
  import cnn_data_pkg::*;

  localparam int IAW = `CNN_IMG_AW;
  localparam int DW  = `CNN_DWIDTH;
  localparam int LW  = `CNN_LWIDTH;

  logic        wr_en;
  logic        ar_mem;
  logic        rd_pend;
  logic        rd_mem;
  logic        rd_img;
  logic [31:0] reg_rdata;
  pixel_t      mem_rdata;

//============================================================
// write channel
//============================================================

  assign s_awready = s_awvalid && s_wvalid && !s_bvalid;
  assign s_wready  = s_awready;
  assign s_bresp   = 2'b00;
  assign wr_en     = s_awready && |s_wstrb;

  always_ff @(posedge clk)
    if (!xrst)
      s_bvalid <= 1'b0;
    else if (s_awready)
      s_bvalid <= 1'b1;
    else if (s_bready)
      s_bvalid <= 1'b0;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      start       <= 1'b0;
      cfg         <= '0;
      host_img_wr <= '0;
      net_wr      <= '0;
      net_sel     <= 1'b0;
    end else begin
      start          <= wr_en && s_awaddr == `CNN_REG_CTRL && s_wdata[0];
      host_img_wr.we <= wr_en && s_awaddr[11];
      net_wr.we      <= wr_en && s_awaddr[11:10] == 2'b01;
      if (wr_en) begin
        host_img_wr.addr <= s_awaddr[10:2];
        host_img_wr.data <= s_wdata[DW-1:0];
        net_wr.addr      <= IAW'(s_awaddr[6:2]);
        net_wr.data      <= s_wdata[DW-1:0];
        net_sel          <= s_awaddr[8];
        case (s_awaddr)
          `CNN_REG_IMG_SIZE:   cfg.img_size   <= s_wdata[LW-1:0];
          `CNN_REG_TOTAL_OUT:  cfg.total_out  <= s_wdata[LW-1:0];
          `CNN_REG_IN_OFFSET:  cfg.in_offset  <= s_wdata[IAW-1:0];
          `CNN_REG_OUT_OFFSET: cfg.out_offset <= s_wdata[IAW-1:0];
          default: ;
        endcase
      end else if (s_arready) begin
        // weight memory host reads share the write address
        net_wr.addr <= IAW'(s_araddr[6:2]);
        net_sel     <= s_araddr[8];
      end
    end
  end

//============================================================
// read channel
//============================================================

  assign s_arready = s_arvalid && !s_rvalid && !rd_pend;
  assign s_rresp   = 2'b00;
  assign ar_mem    = |s_araddr[11:10];

  // memory reads wait one more cycle for the registered port
  always_ff @(posedge clk) begin
    if (!xrst) begin
      s_rvalid <= 1'b0;
      rd_pend  <= 1'b0;
      rd_mem   <= 1'b0;
    end else if (s_arready) begin
      s_rvalid <= !ar_mem;
      rd_pend  <= ar_mem;
      rd_mem   <= ar_mem;
    end else if (rd_pend) begin
      s_rvalid <= 1'b1;
      rd_pend  <= 1'b0;
    end else if (s_rready) begin
      s_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
    if (s_arready) begin
      rd_img         <= s_araddr[11];
      host_img_raddr <= s_araddr[10:2];
      case (s_araddr)
        `CNN_REG_STATUS:     reg_rdata <= {31'b0, done};
        `CNN_REG_IMG_SIZE:   reg_rdata <= 32'(cfg.img_size);
        `CNN_REG_TOTAL_OUT:  reg_rdata <= 32'(cfg.total_out);
        `CNN_REG_IN_OFFSET:  reg_rdata <= 32'(cfg.in_offset);
        `CNN_REG_OUT_OFFSET: reg_rdata <= 32'(cfg.out_offset);
        default:             reg_rdata <= '0;
      endcase
    end

  assign mem_rdata = rd_img ? host_img_rdata : net_host_rdata[net_sel];
  // sign extended
  assign s_rdata   = rd_mem ? 32'(mem_rdata) : reg_rdata;

endmodule

// File: hdl/cnn_data_pkg.sv
`include "cnn_params.svh"

package cnn_data_pkg;

  // Q8.8 fixed point
  typedef logic signed [`CNN_DWIDTH-1:0] pixel_t;
  typedef logic signed [`CNN_DWIDTH-1:0] weight_t;

  typedef logic signed [39:0] acc_t;

  typedef struct packed {
    logic                   we;
    logic [`CNN_IMG_AW-1:0] addr;
    pixel_t                 data;
  } mem_wr_t;

endpackage

// File: hdl/cnn_ctrl_pkg.sv
`include "cnn_params.svh"

package cnn_ctrl_pkg;

  typedef enum logic [1:0] {
    PH_WAIT    = 2'd0,
    PH_NETWORK = 2'd1,
    PH_INPUT   = 2'd2,
    PH_OUTPUT  = 2'd3
  } phase_t;

  // control bus, one word per cycle
  typedef struct packed {
    logic                   start;
    logic                   valid;
    logic                   stop;
    logic [3:0]             kidx;
    logic                   load;
    logic [`CNN_IMG_AW-1:0] out_addr;
  } ctrl_bus_t;

  typedef struct packed {
    logic [`CNN_LWIDTH-1:0] img_size;
    logic [`CNN_LWIDTH-1:0] total_out;
    logic [`CNN_IMG_AW-1:0] in_offset;
    logic [`CNN_IMG_AW-1:0] out_offset;
  } layer_cfg_t;

endpackage

// File: include/cnn_params.svh
`ifndef CNN_PARAMS_SVH
`define CNN_PARAMS_SVH

// datapath
`define CNN_DWIDTH    16
`define CNN_FRAC      8
`define CNN_KSIZE     3
`define CNN_NCORE     2

// memories and counts
`define CNN_IMG_AW    9
`define CNN_NET_AW    5
`define CNN_NET_WORDS 10
`define CNN_LWIDTH    4

// AXI4-Lite register map
`define CNN_REG_CTRL       12'h000
`define CNN_REG_STATUS     12'h004
`define CNN_REG_IMG_SIZE   12'h008
`define CNN_REG_TOTAL_OUT  12'h00C
`define CNN_REG_IN_OFFSET  12'h010
`define CNN_REG_OUT_OFFSET 12'h014
`define CNN_NET_BASE       12'h400
`define CNN_IMG_BASE       12'h800

`endif
